// File: hdl/fadd_norm_pkg.sv
// Shared widths for the FP add normalizer; values are tied to IEEE double with one guard bit
package fadd_norm_pkg;

  // Hidden bit, 52 fraction bits and one guard bit
  parameter int MANT_W = 54;

  // Biased double-precision exponent
  parameter int EXP_W = 11;

  // Shift amount covers 0 to 53
  parameter int SHAMT_W = 6;

  // Default number of lanes in one batch
  parameter int LANES_DEF = 4;

  typedef logic [SHAMT_W-1:0] shamt_t;

endpackage

// File: hdl/onehot_sel_shift.sv
// Select must be one-hot or zero; any other pattern gives X, and the clock only drives the check
`timescale 1ns/1ps

module onehot_sel_shift
  import fadd_norm_pkg::*;
(
  input  logic              forever_cpuclk,
  input  logic [MANT_W-1:0] data_in,
  input  logic [MANT_W-1:0] onehot,
  output logic [MANT_W-1:0] result
);

  logic [MANT_W-1:0] result_d;

  // Each select bit picks the copy of data_in with that bit moved to the top
  always_comb
  begin
    result_d = '0;
    for (int i = 0; i < MANT_W; i++)
    begin
      if (onehot[i])
      begin
        result_d = data_in << (MANT_W - 1 - i);
      end
    end
    // Several select bits set is not a legal select
    if (!$onehot0(onehot))
    begin
      result_d = 'x;
    end
  end

  assign result = result_d;

  // The leading-one search upstream must never hand over more than one select bit
  a_onehot_sel : assert property (@(posedge forever_cpuclk) $onehot0(onehot))
    else $error("onehot_sel_shift: select %h has more than one bit set", onehot);

endmodule

// File: hdl/norm_lane.sv
// One normalizer lane with 1 cycle latency; exponent saturates to zero, no denormal shifting
`timescale 1ns/1ps

module norm_lane
  import fadd_norm_pkg::*;
(
  input  logic              forever_cpuclk,
  input  logic              rst_n,
  input  logic              vld,
  input  logic [MANT_W-1:0] mant,
  input  logic [EXP_W-1:0]  exp,
  output logic              vld_q,
  output logic [MANT_W-1:0] mant_q,
  output logic [EXP_W-1:0]  exp_q,
  output shamt_t            shamt_q,
  output logic              zero_q
);

  logic [MANT_W-1:0] lead_oh;
  logic [MANT_W-1:0] mant_norm;
  logic [EXP_W-1:0]  shamt_ext;
  logic [EXP_W-1:0]  exp_d;
  shamt_t            shamt_d;
  logic              zero_d;

  // Priority search, the highest set bit wins
  always_comb
  begin
    lead_oh = '0;
    shamt_d = '0;
    for (int k = 0; k < MANT_W; k++)
    begin
      if (mant[k])
      begin
        lead_oh    = '0;
        lead_oh[k] = 1'b1;
        shamt_d    = shamt_t'(MANT_W - 1 - k);
      end
    end
  end

  assign zero_d = ~|mant;

  onehot_sel_shift u_shift (
    .forever_cpuclk (forever_cpuclk),
    .data_in        (mant),
    .onehot         (lead_oh),
    .result         (mant_norm)
  );

  // Saturating exponent subtract
  assign shamt_ext = {{(EXP_W - SHAMT_W){1'b0}}, shamt_d};

  always_comb
  begin
    if (zero_d || (shamt_ext >= exp))
    begin
      exp_d = '0;
    end
    else
    begin
      exp_d = exp - shamt_ext;
    end
  end

  always_ff @(posedge forever_cpuclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vld_q   <= 1'b0;
      mant_q  <= '0;
      exp_q   <= '0;
      shamt_q <= '0;
      zero_q  <= 1'b0;
    end
    else
    begin
      vld_q <= vld;
      // Hold results on idle cycles
      if (vld)
      begin
        mant_q  <= mant_norm;
        exp_q   <= exp_d;
        shamt_q <= shamt_d;
        zero_q  <= zero_d;
      end
    end
  end

  // Search and shifter together must leave the leading one at the top
  a_normalized : assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    (vld_q && !zero_q) |-> mant_q[MANT_W-1])
    else $error("norm_lane: non-zero result %h is not normalized", mant_q);

endmodule

// File: hdl/norm_issue.sv
// Batch input register; operands load only on in_vld and there is no back-pressure
`timescale 1ns/1ps

module norm_issue
  import fadd_norm_pkg::*;
#(
  parameter int LANES = 1
)
(
  input  logic                    forever_cpuclk,
  input  logic                    rst_n,
  input  logic                    in_vld,
  input  logic [LANES*MANT_W-1:0] mant_in,
  input  logic [LANES*EXP_W-1:0]  exp_in,
  output logic                    iss_vld,
  output logic [LANES*MANT_W-1:0] iss_mant,
  output logic [LANES*EXP_W-1:0]  iss_exp
);

  always_ff @(posedge forever_cpuclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      iss_vld  <= 1'b0;
      iss_mant <= '0;
      iss_exp  <= '0;
    end
    else
    begin
      iss_vld <= in_vld;
      // Keep old operands when idle so the lanes stay quiet
      if (in_vld)
      begin
        iss_mant <= mant_in;
        iss_exp  <= exp_in;
      end
    end
  end

endmodule

// File: hdl/norm_collect.sv
// Output register for all lanes; results are valid only in the out_vld cycle
`timescale 1ns/1ps

module norm_collect
  import fadd_norm_pkg::*;
#(
  parameter int LANES = 1
)
(
  input  logic                     forever_cpuclk,
  input  logic                     rst_n,
  input  logic                     lane_vld,
  input  logic [LANES*MANT_W-1:0]  lane_mant,
  input  logic [LANES*EXP_W-1:0]   lane_exp,
  input  logic [LANES*SHAMT_W-1:0] lane_shamt,
  input  logic [LANES-1:0]         lane_zero,
  output logic                     out_vld,
  output logic [LANES*MANT_W-1:0]  mant_out,
  output logic [LANES*EXP_W-1:0]   exp_out,
  output logic [LANES-1:0]         zero_flag,
  output logic [LANES-1:0]         unf_flag
);

  logic [LANES-1:0] unf_d;

  // Underflow means a real shift ran the exponent down to zero
  for (genvar i = 0; i < LANES; i++)
  begin : g_unf
    shamt_t           sh;
    logic [EXP_W-1:0] ex;

    assign sh       = lane_shamt[i*SHAMT_W +: SHAMT_W];
    assign ex       = lane_exp[i*EXP_W +: EXP_W];
    assign unf_d[i] = ~lane_zero[i] & (ex == '0) & (sh != '0);
  end

  always_ff @(posedge forever_cpuclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_vld   <= 1'b0;
      mant_out  <= '0;
      exp_out   <= '0;
      zero_flag <= '0;
      unf_flag  <= '0;
    end
    else
    begin
      out_vld <= lane_vld;
      if (lane_vld)
      begin
        mant_out  <= lane_mant;
        exp_out   <= lane_exp;
        zero_flag <= lane_zero;
        unf_flag  <= unf_d;
      end
    end
  end

  // The strobe has to be clean through the whole pipe, inputs included
  a_vld_known : assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    !$isunknown(out_vld))
    else $error("norm_collect: out_vld is unknown");

endmodule

// File: hdl/fadd_norm_top.sv
// Three-cycle normalizer pipe for LANES lanes; inputs and outputs are flat, lane 0 at the LSBs
`timescale 1ns/1ps

module fadd_norm_top
  import fadd_norm_pkg::*;
#(
  parameter int LANES = LANES_DEF
)
(
  input  logic                    forever_cpuclk,
  input  logic                    rst_n,
  input  logic                    in_vld,
  input  logic [LANES*MANT_W-1:0] mant_in,
  input  logic [LANES*EXP_W-1:0]  exp_in,
  output logic                    out_vld,
  output logic [LANES*MANT_W-1:0] mant_out,
  output logic [LANES*EXP_W-1:0]  exp_out,
  output logic [LANES-1:0]        zero_flag,
  output logic [LANES-1:0]        unf_flag
);

  logic                     iss_vld;
  logic [LANES*MANT_W-1:0]  iss_mant;
  logic [LANES*EXP_W-1:0]   iss_exp;
  logic [LANES-1:0]         lane_vld_v;
  logic [LANES*MANT_W-1:0]  lane_mant;
  logic [LANES*EXP_W-1:0]   lane_exp;
  logic [LANES*SHAMT_W-1:0] lane_shamt;
  logic [LANES-1:0]         lane_zero;

  norm_issue #(
    .LANES (LANES)
  ) u_issue (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .in_vld         (in_vld),
    .mant_in        (mant_in),
    .exp_in         (exp_in),
    .iss_vld        (iss_vld),
    .iss_mant       (iss_mant),
    .iss_exp        (iss_exp)
  );

  // All lanes step together, so lane 0 carries the batch strobe
  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    norm_lane u_lane (
      .forever_cpuclk (forever_cpuclk),
      .rst_n          (rst_n),
      .vld            (iss_vld),
      .mant           (iss_mant[i*MANT_W +: MANT_W]),
      .exp            (iss_exp[i*EXP_W +: EXP_W]),
      .vld_q          (lane_vld_v[i]),
      .mant_q         (lane_mant[i*MANT_W +: MANT_W]),
      .exp_q          (lane_exp[i*EXP_W +: EXP_W]),
      .shamt_q        (lane_shamt[i*SHAMT_W +: SHAMT_W]),
      .zero_q         (lane_zero[i])
    );
  end

  norm_collect #(
    .LANES (LANES)
  ) u_collect (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .lane_vld       (lane_vld_v[0]),
    .lane_mant      (lane_mant),
    .lane_exp       (lane_exp),
    .lane_shamt     (lane_shamt),
    .lane_zero      (lane_zero),
    .out_vld        (out_vld),
    .mant_out       (mant_out),
    .exp_out        (exp_out),
    .zero_flag      (zero_flag),
    .unf_flag       (unf_flag)
  );

endmodule

// File: dv/norm_checker.sv
// Samples in_vld and expected values on the rising edge and DUT outputs on the falling edge
`timescale 1ns/1ps

module norm_checker
  import fadd_norm_pkg::*;
#(
  parameter int LANES = 1
)
(
  input  logic                    forever_cpuclk,
  input  logic                    rst_n,
  input  logic                    in_vld,
  input  logic [LANES*MANT_W-1:0] exp_mant,
  input  logic [LANES*EXP_W-1:0]  exp_exp,
  input  logic [LANES-1:0]        exp_zero,
  input  logic [LANES-1:0]        exp_unf,
  input  logic                    out_vld,
  input  logic [LANES*MANT_W-1:0] mant_out,
  input  logic [LANES*EXP_W-1:0]  exp_out,
  input  logic [LANES-1:0]        zero_flag,
  input  logic [LANES-1:0]        unf_flag,
  output int                      err_cnt,
  output int                      pend_cnt
);

  // Three register stages, the first one clocks on the sampling edge itself
  localparam int EDGES_AFTER = 2;
  localparam int DEPTH       = 8;

  logic [LANES*MANT_W-1:0] q_mant  [0:DEPTH-1];
  logic [LANES*EXP_W-1:0]  q_exp   [0:DEPTH-1];
  logic [LANES-1:0]        q_zero  [0:DEPTH-1];
  logic [LANES-1:0]        q_unf   [0:DEPTH-1];
  int                      q_stamp [0:DEPTH-1];
  int                      push_cnt = 0;
  int                      pop_cnt  = 0;
  int                      cyc      = 0;
  int                      errors   = 0;
  int                      rd;

  assign err_cnt  = errors;
  assign pend_cnt = push_cnt - pop_cnt;

  task automatic compare_field(input string what, input int lane,
                               input logic [63:0] got, input logic [63:0] want);
    if (got !== want)
    begin
      $display("[FAIL] %0t ns: batch %0d lane %0d %s is %h, expected %h",
               $time, pop_cnt, lane, what, got, want);
      errors = errors + 1;
    end
  endtask

  // Record each issued batch with the edge that sampled it
  always @(posedge forever_cpuclk)
  begin
    cyc = cyc + 1;
    if (rst_n && in_vld)
    begin
      q_mant[push_cnt % DEPTH]  = exp_mant;
      q_exp[push_cnt % DEPTH]   = exp_exp;
      q_zero[push_cnt % DEPTH]  = exp_zero;
      q_unf[push_cnt % DEPTH]   = exp_unf;
      q_stamp[push_cnt % DEPTH] = cyc;
      push_cnt = push_cnt + 1;
    end
  end

  always @(negedge forever_cpuclk)
  begin
    if (rst_n && out_vld)
    begin
      if (pop_cnt == push_cnt)
      begin
        $display("Unexpected out_vld at %0t ns with no batch in flight", $time);
        errors = errors + 1;
      end
      else
      begin
        rd = pop_cnt % DEPTH;
        if (cyc - q_stamp[rd] != EDGES_AFTER)
        begin
          $display("[FAIL] %0t ns: batch %0d arrived %0d edges after issue, expected %0d",
                   $time, pop_cnt, cyc - q_stamp[rd], EDGES_AFTER);
          errors = errors + 1;
        end
        for (int l = 0; l < LANES; l++)
        begin
          compare_field("mant_out", l, 64'(mant_out[l*MANT_W +: MANT_W]),
                        64'(q_mant[rd][l*MANT_W +: MANT_W]));
          compare_field("exp_out", l, 64'(exp_out[l*EXP_W +: EXP_W]),
                        64'(q_exp[rd][l*EXP_W +: EXP_W]));
          compare_field("zero_flag", l, 64'(zero_flag[l]), 64'(q_zero[rd][l]));
          compare_field("unf_flag", l, 64'(unf_flag[l]), 64'(q_unf[rd][l]));
        end
        pop_cnt = pop_cnt + 1;
      end
    end
    else if (rst_n && push_cnt == 0 && |{mant_out, exp_out, zero_flag, unf_flag})
    begin
      $display("[FAIL] %0t ns: outputs are not zero before the first batch", $time);
      errors = errors + 1;
    end
  end

endmodule

// File: dv/tb_fadd_norm.sv
// Runs 4 lanes from dv/norm_golden.hex, read relative to the project root; waits are 20 cycles max
`timescale 1ns/1ps

module tb_fadd_norm
  import fadd_norm_pkg::*;
();

  localparam int LANES  = LANES_DEF;
  localparam int NBATCH = 6;
  localparam int NWORDS = NBATCH * LANES * 5;

  logic                    forever_cpuclk;
  logic                    rst_n;
  logic                    in_vld;
  logic [LANES*MANT_W-1:0] mant_in;
  logic [LANES*EXP_W-1:0]  exp_in;
  logic                    out_vld;
  logic [LANES*MANT_W-1:0] mant_out;
  logic [LANES*EXP_W-1:0]  exp_out;
  logic [LANES-1:0]        zero_flag;
  logic [LANES-1:0]        unf_flag;
  logic [LANES*MANT_W-1:0] exp_mant;
  logic [LANES*EXP_W-1:0]  exp_exp;
  logic [LANES-1:0]        exp_zero;
  logic [LANES-1:0]        exp_unf;
  logic [63:0]             gold [0:NWORDS-1];
  int                      err_cnt;
  int                      pend_cnt;
  int                      seed = 98646;
  int                      err_before = 0;
  int                      timeouts = 0;
  int                      tests_pass = 0;
  int                      tests_fail = 0;
  int                      gap;

  fadd_norm_top #(.LANES(LANES)) uut (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .in_vld         (in_vld),
    .mant_in        (mant_in),
    .exp_in         (exp_in),
    .out_vld        (out_vld),
    .mant_out       (mant_out),
    .exp_out        (exp_out),
    .zero_flag      (zero_flag),
    .unf_flag       (unf_flag)
  );

  norm_checker #(.LANES(LANES)) u_chk (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .in_vld         (in_vld),
    .exp_mant       (exp_mant),
    .exp_exp        (exp_exp),
    .exp_zero       (exp_zero),
    .exp_unf        (exp_unf),
    .out_vld        (out_vld),
    .mant_out       (mant_out),
    .exp_out        (exp_out),
    .zero_flag      (zero_flag),
    .unf_flag       (unf_flag),
    .err_cnt        (err_cnt),
    .pend_cnt       (pend_cnt)
  );

  always #20 forever_cpuclk = ~forever_cpuclk;

  // Five golden words per lane with lane 0 first
  task automatic issue_batch(input int b);
    int base;
    @(negedge forever_cpuclk);
    for (int l = 0; l < LANES; l++)
    begin
      base = (b * LANES + l) * 5;
      mant_in[l*MANT_W +: MANT_W]  = gold[base][MANT_W-1:0];
      exp_in[l*EXP_W +: EXP_W]     = gold[base+1][EXP_W-1:0];
      exp_mant[l*MANT_W +: MANT_W] = gold[base+2][MANT_W-1:0];
      exp_exp[l*EXP_W +: EXP_W]    = gold[base+3][EXP_W-1:0];
      exp_zero[l]                  = gold[base+4][0];
      exp_unf[l]                   = gold[base+4][1];
    end
    in_vld = 1'b1;
  endtask

  task automatic go_idle();
    @(negedge forever_cpuclk);
    in_vld = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    #1;
    while (pend_cnt != 0 && cycles < 20)
    begin
      @(negedge forever_cpuclk);
      #1;
      cycles++;
    end
    if (pend_cnt != 0)
    begin
      $display("Timeout: %0d batches still had no out_vld after 20 cycles", pend_cnt);
      timeouts++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt + timeouts == err_before)
    begin
      tests_pass++;
      $display("Test %s: passed", name);
    end
    else
    begin
      tests_fail++;
      $display("Test %s: %0d failures", name, err_cnt + timeouts - err_before);
    end
    err_before = err_cnt + timeouts;
  endtask

  initial
  begin
    forever_cpuclk = 1'b0;
    rst_n          = 1'b0;
    in_vld         = 1'b0;
    mant_in        = '0;
    exp_in         = '0;
    exp_mant       = '0;
    exp_exp        = '0;
    exp_zero       = '0;
    exp_unf        = '0;
    $readmemh("dv/norm_golden.hex", gold);
    repeat (16) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    rst_n = 1'b1;

    repeat (6) @(negedge forever_cpuclk);
    end_test("idle after reset");

    issue_batch(0);
    go_idle();
    wait_drained();
    end_test("single batch leading-one positions");

    issue_batch(1);
    go_idle();
    wait_drained();
    end_test("zero mantissas");

    issue_batch(2);
    go_idle();
    wait_drained();
    end_test("exponent underflow");

    issue_batch(3);
    issue_batch(4);
    issue_batch(5);
    go_idle();
    wait_drained();
    end_test("back-to-back batches");

    for (int b = 0; b < NBATCH; b++)
    begin
      issue_batch(b);
      gap = $random(seed) & 3;
      repeat (gap) go_idle();
    end
    go_idle();
    wait_drained();
    repeat (4) @(negedge forever_cpuclk);
    end_test("random idle gaps");

    $display("Tests passed: %0d, failed: %0d", tests_pass, tests_fail);
    if (tests_fail == 0 && err_cnt == 0 && timeouts == 0)
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: dv/norm_golden.hex
// Columns: mant_in exp_in mant_out exp_out flags (bit 0 zero, bit 1 underflow)
// Four lines form one batch, lane 0 first
20000000000000 3FF 20000000000000 3FF 0
00000000000001 3FF 20000000000000 3CA 0
00000012345678 400 2468ACF0000000 3E7 0
0ABCDEF0123456 100 2AF37BC048D158 0FE 0
00000000000000 3FF 00000000000000 000 1
00000000000000 000 00000000000000 000 1
00000000000000 7FF 00000000000000 000 1
30000000000000 001 30000000000000 001 0
00000000000001 005 20000000000000 000 2
00000000000100 02D 20000000000000 000 2
00000000000100 02E 20000000000000 001 0
00000000FFFFFF 01E 3FFFFFC0000000 000 2
10000000000000 7FE 20000000000000 7FD 0
01000000000000 010 20000000000000 00B 0
00000000000003 400 30000000000000 3CC 0
00000000000000 123 00000000000000 000 1
00000000000002 034 20000000000000 000 2
3FFFFFFFFFFFFF 7FF 3FFFFFFFFFFFFF 7FF 0
00000080000000 016 20000000000000 000 2
00000080000000 017 20000000000000 001 0
00000000000005 0FF 28000000000000 0CC 0
02000000000000 005 20000000000000 001 0
00000000000000 000 00000000000000 000 1
15555555555555 001 2AAAAAAAAAAAAA 000 2

// File: fadd_norm.f
hdl/fadd_norm_pkg.sv
hdl/onehot_sel_shift.sv
hdl/norm_lane.sv
hdl/norm_issue.sv
hdl/norm_collect.sv
hdl/fadd_norm_top.sv
dv/norm_checker.sv
dv/tb_fadd_norm.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the normalizer testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f fadd_norm.f --top-module tb_fadd_norm -o sim_fadd_norm
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_fadd_norm)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
